// File: project.f
src/rv_pkg.sv
src/rv_stage_if.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_exec.sv
src/rv_regs.sv
src/rv_core.sv
verif/rv_core_asserts.sv
verif/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_core --Mdir obj_dir -o sim_tb -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0

// File: src/rv_core.sv
module rv_core (
    input  wire                                 i_clk,
    input  wire                                 i_rst_n,
    // instruction interface
    output logic                                o_instr_req,
    output logic [rv_pkg::IADDR_BITS-1:0]       o_instr_addr,
    input  wire                                 i_instr_ack,
    input  wire [31:0]                          i_instr_data,
    // retirement trace
    output logic                                o_wb_valid,
    output logic [rv_pkg::REG_IDX_BITS-1:0]     o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]             o_wb_data
);

    logic                               fetch_valid;
    logic [31:0]                        fetch_instr;
    logic [rv_pkg::IADDR_BITS-1:0]      fetch_pc;
    logic                               pc_select;
    logic [rv_pkg::IADDR_BITS-1:0]      pc_target;
    logic [rv_pkg::REG_IDX_BITS-1:0]    raddr1;
    logic [rv_pkg::REG_IDX_BITS-1:0]    raddr2;
    logic [rv_pkg::XLEN-1:0]            rdata1;
    logic [rv_pkg::XLEN-1:0]            rdata2;

    rv_stage_if u_stage ();

    rv_fetch u_fetch (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_instr_ack    (i_instr_ack),
        .i_instr_data   (i_instr_data),
        .i_pc_select    (pc_select),
        .i_pc_target    (pc_target),
        .o_instr_req    (o_instr_req),
        .o_instr_addr   (o_instr_addr),
        .o_valid        (fetch_valid),
        .o_instr        (fetch_instr),
        .o_pc           (fetch_pc)
    );

    rv_decode u_decode (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (fetch_valid),
        .i_instr        (fetch_instr),
        .i_pc           (fetch_pc),
        .i_pc_select    (pc_select),
        .stage          (u_stage.dec)
    );

    rv_exec u_exec (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .stage          (u_stage.exe),
        .i_rdata1       (rdata1),
        .i_rdata2       (rdata2),
        .o_raddr1       (raddr1),
        .o_raddr2       (raddr2),
        .o_pc_select    (pc_select),
        .o_pc_target    (pc_target),
        .o_wb_valid     (o_wb_valid),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data)
    );

    // write port is fed straight from the write-back register
    rv_regs u_regs (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_raddr1       (raddr1),
        .i_raddr2       (raddr2),
        .o_rdata1       (rdata1),
        .o_rdata2       (rdata2),
        .i_we           (o_wb_valid),
        .i_waddr        (o_wb_rd),
        .i_wdata        (o_wb_data)
    );

endmodule

// File: src/rv_decode.sv
module rv_decode (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire                             i_valid,
    input  wire [31:0]                      i_instr,
    input  wire [rv_pkg::IADDR_BITS-1:0]    i_pc,
    input  wire                             i_pc_select,
    rv_stage_if.dec                         stage
);

    rv_pkg::instr_u             w;
    rv_pkg::alu_op_t            alu_op;
    logic [rv_pkg::XLEN-1:0]    imm;
    logic                       use_imm;
    logic                       reg_write;
    logic                       is_branch;

    function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            rv_pkg::F3_ADD_SUB: return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:     return rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:     return rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU:    return rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:     return rv_pkg::ALU_XOR;
            rv_pkg::F3_SRL_SRA: return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:      return rv_pkg::ALU_OR;
            default:            return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign w = i_instr;

    always_comb begin
        alu_op    = rv_pkg::ALU_ADD;
        imm       = '0;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        is_branch = 1'b0;
        case (w.r.opcode)
            rv_pkg::OPC_OP: begin
                reg_write = 1'b1;
                alu_op    = alu_sel(w.r.funct3, w.r.funct7[5]);
            end
            rv_pkg::OPC_OP_IMM: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                imm       = {{20{w.i.imm[11]}}, w.i.imm};
                // addi has no sub form so only the right shift looks at bit 30
                alu_op    = alu_sel(w.i.funct3,
                                    (w.i.funct3 == rv_pkg::F3_SRL_SRA) & w.i.imm[10]);
            end
            rv_pkg::OPC_LUI: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = rv_pkg::ALU_PASS_B;
                imm       = {w.r.funct7, w.r.rs2, w.r.rs1, w.r.funct3, 12'b0};
            end
            rv_pkg::OPC_BRANCH: begin
                is_branch = 1'b1;
                imm       = {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5,
                             w.b.imm_4_1, 1'b0};
            end
            default: ;
        endcase
        // x0 destination retires nothing
        if (w.i.rd == '0)
            reg_write = 1'b0;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            stage.valid <= 1'b0;
        else
            stage.valid <= i_valid & ~i_pc_select;
    end

    always_ff @(posedge i_clk) begin
        stage.pc        <= i_pc;
        stage.rs1       <= w.b.rs1;
        stage.rs2       <= w.b.rs2;
        stage.rd        <= w.i.rd;
        stage.imm       <= imm;
        stage.alu_op    <= alu_op;
        stage.use_imm   <= use_imm;
        stage.reg_write <= reg_write;
        stage.is_branch <= is_branch;
        stage.funct3    <= w.b.funct3;
    end

endmodule

// File: src/rv_exec.sv
module rv_exec (
    input  wire                                 i_clk,
    input  wire                                 i_rst_n,
    rv_stage_if.exe                             stage,
    input  wire [rv_pkg::XLEN-1:0]              i_rdata1,
    input  wire [rv_pkg::XLEN-1:0]              i_rdata2,
    output logic [rv_pkg::REG_IDX_BITS-1:0]     o_raddr1,
    output logic [rv_pkg::REG_IDX_BITS-1:0]     o_raddr2,
    output logic                                o_pc_select,
    output logic [rv_pkg::IADDR_BITS-1:0]       o_pc_target,
    output logic                                o_wb_valid,
    output logic [rv_pkg::REG_IDX_BITS-1:0]     o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]             o_wb_data
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] src_b;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] result;
    logic [4:0]              shamt;
    logic                    cond;

    assign o_raddr1 = stage.rs1;
    assign o_raddr2 = stage.rs2;

    // wb_valid is never set for x0, so a match is always a real register
    assign op_a  = (o_wb_valid && o_wb_rd == stage.rs1) ? o_wb_data : i_rdata1;
    assign src_b = (o_wb_valid && o_wb_rd == stage.rs2) ? o_wb_data : i_rdata2;
    assign op_b  = stage.use_imm ? stage.imm : src_b;
    assign shamt = op_b[4:0];

    always_comb begin
        result = '0;
        case (stage.alu_op)
            rv_pkg::ALU_ADD:    result = op_a + op_b;
            rv_pkg::ALU_SUB:    result = op_a - op_b;
            rv_pkg::ALU_AND:    result = op_a & op_b;
            rv_pkg::ALU_OR:     result = op_a | op_b;
            rv_pkg::ALU_XOR:    result = op_a ^ op_b;
            rv_pkg::ALU_SLL:    result = op_a << shamt;
            rv_pkg::ALU_SRL:    result = op_a >> shamt;
            rv_pkg::ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_SLT:    result[0] = $signed(op_a) < $signed(op_b);
            rv_pkg::ALU_SLTU:   result[0] = op_a < op_b;
            rv_pkg::ALU_PASS_B: result = op_b;
            default:            result = '0;
        endcase
    end

    always_comb begin
        case (stage.funct3)
            rv_pkg::F3_BEQ: cond = op_a == src_b;
            rv_pkg::F3_BNE: cond = op_a != src_b;
            rv_pkg::F3_BLT: cond = $signed(op_a) < $signed(src_b);
            rv_pkg::F3_BGE: cond = $signed(op_a) >= $signed(src_b);
            default:        cond = 1'b0;
        endcase
    end

    assign o_pc_select = stage.valid & stage.is_branch & cond;
    assign o_pc_target = stage.pc + stage.imm[rv_pkg::IADDR_BITS-1:0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_wb_valid <= 1'b0;
        else
            o_wb_valid <= stage.valid & stage.reg_write;
    end

    always_ff @(posedge i_clk) begin
        if (stage.valid & stage.reg_write) begin
            o_wb_rd   <= stage.rd;
            o_wb_data <= result;
        end
    end

endmodule

// File: src/rv_fetch.sv
module rv_fetch (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire                             i_instr_ack,
    input  wire [31:0]                      i_instr_data,
    input  wire                             i_pc_select,
    input  wire [rv_pkg::IADDR_BITS-1:0]    i_pc_target,
    output logic                            o_instr_req,
    output logic [rv_pkg::IADDR_BITS-1:0]   o_instr_addr,
    output logic                            o_valid,
    output logic [31:0]                     o_instr,
    output logic [rv_pkg::IADDR_BITS-1:0]   o_pc
);

    logic [rv_pkg::IADDR_BITS-1:0] pc;
    logic                          req;
    logic                          take;

    assign take = req & i_instr_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc      <= rv_pkg::RESET_ADDR;
            req     <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            req <= 1'b1;
            // a redirect wins over the word acknowledged in the same cycle
            if (i_pc_select)
                pc <= i_pc_target;
            else if (take)
                pc <= pc + (rv_pkg::IADDR_BITS)'(4);
            o_valid <= take & ~i_pc_select;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            o_instr <= i_instr_data;
            o_pc    <= pc;
        end
    end

    assign o_instr_req  = req;
    assign o_instr_addr = pc;

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    localparam int IADDR_BITS   = 16;
    localparam logic [IADDR_BITS-1:0] RESET_ADDR = '0;
    localparam int XLEN         = 32;
    localparam int REG_IDX_BITS = 5;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // alu funct3 shared by reg-reg and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_t;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
    } instr_u;

endpackage

// File: src/rv_regs.sv
module rv_regs (
    input  wire                                 i_clk,
    input  wire                                 i_rst_n,
    input  wire [rv_pkg::REG_IDX_BITS-1:0]      i_raddr1,
    input  wire [rv_pkg::REG_IDX_BITS-1:0]      i_raddr2,
    output logic [rv_pkg::XLEN-1:0]             o_rdata1,
    output logic [rv_pkg::XLEN-1:0]             o_rdata2,
    input  wire                                 i_we,
    input  wire [rv_pkg::REG_IDX_BITS-1:0]      i_waddr,
    input  wire [rv_pkg::XLEN-1:0]              i_wdata
);

    // x0 is not stored
    logic [rv_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: src/rv_stage_if.sv
interface rv_stage_if;

    logic                              valid;
    logic [rv_pkg::IADDR_BITS-1:0]     pc;
    logic [rv_pkg::REG_IDX_BITS-1:0]   rs1;
    logic [rv_pkg::REG_IDX_BITS-1:0]   rs2;
    logic [rv_pkg::REG_IDX_BITS-1:0]   rd;
    logic [rv_pkg::XLEN-1:0]           imm;
    rv_pkg::alu_op_t                   alu_op;
    logic                              use_imm;
    logic                              reg_write;
    logic                              is_branch;
    // branch condition
    logic [2:0]                        funct3;

    modport dec (output valid, pc, rs1, rs2, rd, imm, alu_op, use_imm, reg_write,
                 is_branch, funct3);
    modport exe (input valid, pc, rs1, rs2, rd, imm, alu_op, use_imm, reg_write,
                 is_branch, funct3);

endinterface

// File: verif/rv_core_asserts.sv
module rv_core_asserts (
    input wire                                  i_clk,
    input wire                                  i_rst_n,
    input wire                                  i_instr_req,
    input wire [rv_pkg::IADDR_BITS-1:0]         i_instr_addr,
    input wire                                  i_instr_ack,
    input wire                                  i_pc_select,
    input wire                                  i_wb_valid,
    input wire [rv_pkg::REG_IDX_BITS-1:0]       i_wb_rd
);
    timeunit 1ns;
    timeprecision 1ps;

    wb_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_valid |-> (i_wb_rd != '0))
        else $error("write-back pulse for register zero");

    // a waiting request keeps its address unless a branch redirects it
    req_addr_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_instr_req && !i_instr_ack && !i_pc_select) |=> $stable(i_instr_addr))
        else $error("fetch address moved while the request waited");

    idle_in_reset: assert property (@(posedge i_clk)
        !i_rst_n |-> (!i_instr_req && !i_wb_valid))
        else $error("request or write-back active during reset");

endmodule

bind rv_core rv_core_asserts asserts_i (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_instr_req    (o_instr_req),
    .i_instr_addr   (o_instr_addr),
    .i_instr_ack    (i_instr_ack),
    .i_pc_select    (pc_select),
    .i_wb_valid     (o_wb_valid),
    .i_wb_rd        (o_wb_rd)
);

// File: verif/rv_core_vectors.txt
// program word count, then program words from address 0
// retirement count, then rd and value per line, all hex
27
800000B7 FFB00113 00700193 00310233
403202B3 00419333 0030D3B3 4030D433
003124B3 00313533 003145B3 00326633
003176B3 0F017713 FF01E793 00419813
4040D893 FFF1B913 00518013 0000098B
003009B3 00C18663 00100A13 00200A13
00419663 00300A13 00400A13 00314663
00500A13 00600A13 0021D663 00700A13
00800A13 00418663 05500A93 000A9663
00900A13 00A00A13 001A0A13
15
01 80000000
02 FFFFFFFB
03 00000007
04 00000002
05 FFFFFFFB
06 0000001C
07 01000000
08 FF000000
09 00000001
0A 00000000
0B FFFFFFFC
0C 00000007
0D 00000003
0E 000000F0
0F FFFFFFF7
10 00000070
11 F8000000
12 00000001
13 00000007
15 00000055
14 00000001

// File: verif/tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          VEC_WORDS    = 256;
    localparam int          DRAIN_CYCLES = 8;
    localparam logic [31:0] NOP_WORD     = 32'h0000_0013;

    logic                               clk;
    logic                               rst_n;
    logic                               instr_ack;
    logic [31:0]                        instr_data;
    logic                               instr_req;
    logic [rv_pkg::IADDR_BITS-1:0]      instr_addr;
    logic                               wb_valid;
    logic [rv_pkg::REG_IDX_BITS-1:0]    wb_rd;
    logic [rv_pkg::XLEN-1:0]            wb_data;

    logic [31:0]                        vec [0:VEC_WORDS-1];
    logic [31:0]                        exp_word;
    logic [rv_pkg::REG_IDX_BITS-1:0]    exp_rd;
    logic [rv_pkg::XLEN-1:0]            exp_data;
    integer                             seed;
    int                                 prog_len;
    int                                 exp_count;
    int                                 retired;
    int                                 errors;
    int                                 cycles;
    int                                 cycle_limit;
    int                                 wait_left;

    rv_core dut_i (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .o_instr_req    (instr_req),
        .o_instr_addr   (instr_addr),
        .i_instr_ack    (instr_ack),
        .i_instr_data   (instr_data),
        .o_wb_valid     (wb_valid),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] vector_word(input int pos);
        return vec[8'(pos)];
    endfunction

    // program word for a byte address or a nop past the end
    function automatic logic [31:0] word_at(input logic [rv_pkg::IADDR_BITS-1:0] addr);
        int idx;
        idx = int'(addr[rv_pkg::IADDR_BITS-1:2]);
        if (idx < prog_len)
            return vector_word(idx + 1);
        return NOP_WORD;
    endfunction

    function automatic int draw_wait_cycles();
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'd3);
    endfunction

    // instruction memory answering for the address present at the ack
    always @(posedge clk) begin
        #1;
        if (!instr_req) begin
            instr_ack = 1'b0;
        end else if (wait_left > 0) begin
            instr_ack = 1'b0;
            wait_left = wait_left - 1;
        end else begin
            instr_ack  = 1'b1;
            instr_data = word_at(instr_addr);
            wait_left  = draw_wait_cycles();
        end
    end

    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (retired >= exp_count) begin
                $display("unexpected retirement past the end of the list, rd %0d", wb_rd);
                errors++;
            end else begin
                exp_word = vector_word(prog_len + 2 + 2 * retired);
                exp_rd   = exp_word[rv_pkg::REG_IDX_BITS-1:0];
                exp_data = vector_word(prog_len + 3 + 2 * retired);
                assert (wb_rd == exp_rd) else begin
                    $display("ERR o_wb_rd got %h expected %h at retirement %0d",
                             wb_rd, exp_rd, retired);
                    errors++;
                end
                assert (wb_data == exp_data) else begin
                    $display("ERR o_wb_data got %h expected %h at retirement %0d",
                             wb_data, exp_data, retired);
                    errors++;
                end
            end
            retired++;
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        instr_ack  = 1'b0;
        instr_data = '0;
        seed       = 32'h88559c6b;
        wait_left  = 0;
        errors     = 0;
        retired    = 0;
        cycles     = 0;
        exp_count  = 0;
        $readmemh("verif/rv_core_vectors.txt", vec);
        prog_len = int'(vector_word(0));
        if (prog_len < 1 || prog_len > VEC_WORDS - 3) begin
            $display("vector file gives an impossible program length %0d", prog_len);
            errors++;
            prog_len = 0;
        end else begin
            exp_count = int'(vector_word(prog_len + 1));
            if (prog_len + 2 + 2 * exp_count > VEC_WORDS) begin
                $display("vector file gives too many expected retirements");
                errors++;
                exp_count = 0;
            end
        end
        cycle_limit = prog_len * 4 + 20;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        assert (instr_req == 1'b1) else begin
            $display("ERR o_instr_req got %h expected %h", instr_req, 1'b1);
            errors++;
        end
        assert (instr_addr == rv_pkg::RESET_ADDR) else begin
            $display("ERR o_instr_addr got %h expected %h", instr_addr, rv_pkg::RESET_ADDR);
            errors++;
        end

        while (retired < exp_count && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (retired < exp_count) begin
            $display("timeout after %0d cycles, only %0d of %0d retirements seen",
                     cycles, retired, exp_count);
            errors++;
        end else begin
            // catch stray retirements after the last expected one
            repeat (DRAIN_CYCLES) @(posedge clk);
        end

        $display("retired %0d of %0d expected, %0d errors", retired, exp_count, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
